/* design/riscv_dmem_ram.sv */
// Tightly coupled data RAM
`timescale 1ns/100ps

module riscv_dmem_ram
  import riscv_mem_pkg::*;
#(
  parameter int XLEN       = 64,
  parameter int DMEM_WORDS = 64
) (
  input  logic            clk,
  input  logic            rstn,

  // Request from the LSU
  input  logic            dmem_req,
  input  logic            dmem_we,
  input  mem_size_e       dmem_size,
  input  logic [XLEN-1:0] dmem_adr,
  input  logic [XLEN-1:0] dmem_d,

  // Response, one cycle later
  output logic            dmem_ack,
  output logic [XLEN-1:0] dmem_q,
  output logic            dmem_misaligned
);

  localparam int BYTES = XLEN / 8;
  localparam int OFS_W = $clog2(BYTES);
  localparam int IDX_W = $clog2(DMEM_WORDS);

  logic [XLEN-1:0]  mem [DMEM_WORDS];

  logic [OFS_W-1:0] ofs;
  logic [IDX_W-1:0] idx;
  logic [3:0]       nbytes;
  logic [BYTES-1:0] be;
  logic             misaligned_c;

  ////////////////////
  // Lane decode

  assign ofs    = dmem_adr[OFS_W-1:0];
  assign idx    = dmem_adr[OFS_W +: IDX_W];  // Upper address bits ignored
  assign nbytes = size_bytes(dmem_size);

  // Offset must be a multiple of the access size
  assign misaligned_c = (4'(ofs) & (nbytes - 4'd1)) != 4'd0;
  assign be           = BYTES'(((1 << nbytes) - 1) << ofs);

  ////////////////////
  // Storage

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      for (int i = 0; i < DMEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (dmem_req && dmem_we && !misaligned_c) begin
      for (int b = 0; b < BYTES; b++) begin
        if (be[b]) begin
          mem[idx][8*b +: 8] <= dmem_d[8*b +: 8];  // Enabled bytes only
        end
      end
    end
  end

  // Whole word back, the aligner picks the bytes
  always_ff @(posedge clk) begin
    if (dmem_req) begin
      dmem_q <= mem[idx];
    end
  end

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      dmem_ack        <= 1'b0;
      dmem_misaligned <= 1'b0;
    end else begin
      dmem_ack        <= dmem_req;  // Misaligned is acked too
      dmem_misaligned <= dmem_req && misaligned_c;
    end
  end

endmodule

/* design/riscv_isa_pkg.sv */
// RISC-V load/store ISA definitions
package riscv_isa_pkg;

  ////////////////////
  // Instruction width

  localparam int ILEN = 32;  // No compressed forms here

  ////////////////////
  // Major opcodes

  // Instruction bits 6:2, the low two bits are always 2'b11
  typedef enum logic [4:0] {
    OPC_LOAD     = 5'b00000,
    OPC_MISC_MEM = 5'b00011,
    OPC_OP_IMM   = 5'b00100,
    OPC_AUIPC    = 5'b00101,
    OPC_OP_IMM32 = 5'b00110,
    OPC_STORE    = 5'b01000,
    OPC_AMO      = 5'b01011,  // Decoded as non-memory in this LSU
    OPC_OP       = 5'b01100,
    OPC_LUI      = 5'b01101,
    OPC_OP32     = 5'b01110,
    OPC_BRANCH   = 5'b11000,
    OPC_JALR     = 5'b11001,
    OPC_JAL      = 5'b11011,
    OPC_SYSTEM   = 5'b11100
  } opcode_e;

  ////////////////////
  // Load funct3

  typedef enum logic [2:0] {
    LB  = 3'b000,
    LH  = 3'b001,
    LW  = 3'b010,
    LD  = 3'b011,  // RV64 only
    LBU = 3'b100,
    LHU = 3'b101,
    LWU = 3'b110   // RV64 only
  } load_funct_e;

  // Store funct3
  typedef enum logic [2:0] {
    SB = 3'b000,
    SH = 3'b001,
    SW = 3'b010,
    SD = 3'b011    // RV64 only
  } store_funct_e;

endpackage

/* design/riscv_load_align.sv */
// Load data aligner
`timescale 1ns/100ps

module riscv_load_align
  import riscv_mem_pkg::*;
#(
  parameter int XLEN = 64
) (
  input  logic                         clk,
  input  logic                         rstn,

  // Request fields from the LSU
  input  logic                         dmem_req,
  input  logic                         dmem_we,
  input  logic                         dmem_unsigned,
  input  mem_size_e                    dmem_size,
  input  logic [$clog2(XLEN/8)-1:0]    dmem_adr,   // Byte offset bits

  // RAM response
  input  logic                         dmem_ack,
  input  logic [XLEN-1:0]              dmem_q,
  input  logic                         dmem_misaligned,

  output logic                         load_valid,
  output logic [XLEN-1:0]              load_q,
  output logic                         misaligned
);

  localparam int OFS_W = $clog2(XLEN / 8);

  logic             we_r;
  logic             uns_r;
  mem_size_e        size_r;
  logic [OFS_W-1:0] ofs_r;

  logic [XLEN-1:0]  shifted;
  logic [XLEN-1:0]  ext;

  // LSU may change the fields next cycle
  always_ff @(posedge clk) begin
    if (dmem_req) begin
      we_r   <= dmem_we;
      uns_r  <= dmem_unsigned;
      size_r <= dmem_size;
      ofs_r  <= dmem_adr;
    end
  end

  ////////////////////
  // Shift and extend

  assign shifted = dmem_q >> {ofs_r, 3'b000};

  always_comb begin
    case (size_r)
      BYTE:    ext = uns_r ? XLEN'(shifted[7:0]) : XLEN'($signed(shifted[7:0]));
      HWORD:   ext = uns_r ? XLEN'(shifted[15:0]) : XLEN'($signed(shifted[15:0]));
      WORD:    ext = uns_r ? XLEN'(shifted[31:0]) : XLEN'($signed(shifted[31:0]));
      default: ext = shifted;  // DWORD
    endcase
  end

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      load_valid <= 1'b0;
      misaligned <= 1'b0;
    end else begin
      load_valid <= dmem_ack && !we_r && !dmem_misaligned;
      misaligned <= dmem_ack && dmem_misaligned;  // Loads and stores
    end
  end

  always_ff @(posedge clk) begin
    if (dmem_ack && !we_r) begin
      load_q <= ext;
    end
  end

endmodule

/* design/riscv_lsu.sv */
// Load store unit
`timescale 1ns/100ps

module riscv_lsu
  import riscv_isa_pkg::*;
  import riscv_mem_pkg::*;
#(
  parameter int XLEN           = 64,
  parameter int EXCEPTION_SIZE = 16
) (
  input  logic                      clk,
  input  logic                      rstn,

  input  logic                      ex_stall,

  // Instruction from decode
  input  logic                      id_bubble,
  input  logic [ILEN-1:0]           id_instr,
  output logic                      lsu_bubble,

  // Exception vectors of every stage
  input  logic [EXCEPTION_SIZE-1:0] id_exception,
  input  logic [EXCEPTION_SIZE-1:0] ex_exception,
  input  logic [EXCEPTION_SIZE-1:0] mem_exception,
  input  logic [EXCEPTION_SIZE-1:0] wb_exception,
  output logic [EXCEPTION_SIZE-1:0] lsu_exception,

  // Operands
  input  logic [XLEN-1:0]           opA,
  input  logic [XLEN-1:0]           opB,

  // Data memory request
  output logic                      dmem_req,
  output logic                      dmem_we,
  output logic                      dmem_unsigned,
  output mem_size_e                 dmem_size,
  output logic [XLEN-1:0]           dmem_adr,
  output logic [XLEN-1:0]           dmem_d
);

  localparam bit XLEN32 = (XLEN == 32);
  localparam int OFS_W  = $clog2(XLEN / 8);  // Byte offset within a word

  // Access control has one resting state
  typedef enum logic [0:0] {
    IDLE = 1'b0
  } lsu_state_e;

  lsu_state_e        state;

  opcode_e           opcode;
  logic [2:0]        funct3;
  load_funct_e       funct3_ld;
  store_funct_e      funct3_st;
  logic [XLEN-1:0]   imm_s;

  mem_size_e         size_ld;
  mem_size_e         size_st;
  logic              is_load;
  logic              is_store;
  logic              any_exc;
  logic              accept;

  logic [XLEN-1:0]   adr;
  logic [XLEN-1:0]   d;
  logic [OFS_W+2:0]  lane_sh;

  ////////////////////
  // Decode

  assign opcode    = opcode_e'(id_instr[6:2]);
  assign funct3    = id_instr[14:12];
  assign funct3_ld = load_funct_e'(funct3);
  assign funct3_st = store_funct_e'(funct3);

  // S-type immediate, sign extended
  assign imm_s = {{(XLEN-12){id_instr[31]}}, id_instr[31:25], id_instr[11:7]};

  always_comb begin
    case (funct3_ld)
      LB, LBU: size_ld = BYTE;
      LH, LHU: size_ld = HWORD;
      LW:      size_ld = WORD;
      LWU:     size_ld = XLEN32 ? UNDEF_SIZE : WORD;   // RV64 only
      LD:      size_ld = XLEN32 ? UNDEF_SIZE : DWORD;  // RV64 only
      default: size_ld = UNDEF_SIZE;
    endcase
  end

  always_comb begin
    case (funct3_st)
      SB:      size_st = BYTE;
      SH:      size_st = HWORD;
      SW:      size_st = WORD;
      SD:      size_st = XLEN32 ? UNDEF_SIZE : DWORD;
      default: size_st = UNDEF_SIZE;
    endcase
  end

  // Illegal funct3 falls back to non-memory
  assign is_load  = (opcode == OPC_LOAD) && (size_ld != UNDEF_SIZE);
  assign is_store = (opcode == OPC_STORE) && (size_st != UNDEF_SIZE);

  assign any_exc = |{id_exception, ex_exception, mem_exception, wb_exception};
  assign accept  = !ex_stall && !id_bubble && !any_exc && (is_load || is_store);

  ////////////////////
  // Address and store data

  assign adr     = opA + (is_store ? imm_s : opB);  // Loads use opA + opB
  assign lane_sh = {adr[OFS_W-1:0], 3'b000};          // 8 * byte offset

  always_comb begin
    case (size_st)
      BYTE:    d = XLEN'(opB[7:0]) << lane_sh;
      HWORD:   d = XLEN'(opB[15:0]) << lane_sh;
      WORD:    d = XLEN32 ? opB : XLEN'(opB[31:0]) << lane_sh;
      default: d = opB;  // SD, full word
    endcase
  end

  ////////////////////
  // Access control

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      state      <= IDLE;
      dmem_req   <= 1'b0;
      lsu_bubble <= 1'b1;
    end else begin
      case (state)
        IDLE: begin
          dmem_req   <= accept;   // One-cycle pulse
          lsu_bubble <= !accept;
          state      <= IDLE;
        end
        default: begin
          dmem_req   <= 1'b0;
          lsu_bubble <= 1'b1;
          state      <= IDLE;
        end
      endcase
    end
  end

  // Request fields, held until the next accepted access
  always_ff @(posedge clk) begin
    if (accept) begin
      dmem_we       <= is_store;
      dmem_unsigned <= is_load && (funct3_ld inside {LBU, LHU, LWU});
      dmem_size     <= is_store ? size_st : size_ld;
      dmem_adr      <= adr;
      dmem_d        <= d;
    end
  end

  // Decode exceptions move on every cycle
  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      lsu_exception <= '0;
    end else begin
      lsu_exception <= id_exception;
    end
  end

endmodule

/* design/riscv_lsu_top.sv */
// Load store unit with data RAM
`timescale 1ns/100ps

module riscv_lsu_top
  import riscv_isa_pkg::*;
  import riscv_mem_pkg::*;
#(
  parameter int XLEN           = 64,
  parameter int EXCEPTION_SIZE = 16,
  parameter int DMEM_WORDS     = 64
) (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      ex_stall,
  input  logic                      id_bubble,
  input  logic [ILEN-1:0]           id_instr,
  input  logic [EXCEPTION_SIZE-1:0] id_exception,
  input  logic [EXCEPTION_SIZE-1:0] ex_exception,
  input  logic [EXCEPTION_SIZE-1:0] mem_exception,
  input  logic [EXCEPTION_SIZE-1:0] wb_exception,
  input  logic [XLEN-1:0]           opA,
  input  logic [XLEN-1:0]           opB,

  output logic                      lsu_bubble,
  output logic [EXCEPTION_SIZE-1:0] lsu_exception,
  output logic                      load_valid,
  output logic [XLEN-1:0]           load_q,
  output logic                      misaligned
);

  localparam int OFS_W = $clog2(XLEN / 8);

  // LSU to RAM and aligner
  logic            dmem_req;
  logic            dmem_we;
  logic            dmem_unsigned;
  mem_size_e       dmem_size;
  logic [XLEN-1:0] dmem_adr;
  logic [XLEN-1:0] dmem_d;

  // RAM to aligner
  logic            dmem_ack;
  logic [XLEN-1:0] dmem_q;
  logic            dmem_misaligned;

  riscv_lsu #(
    .XLEN           (XLEN),
    .EXCEPTION_SIZE (EXCEPTION_SIZE)
  ) riscv_lsu_inst (
    .clk            (clk),
    .rstn           (rstn),
    .ex_stall       (ex_stall),
    .id_bubble      (id_bubble),
    .id_instr       (id_instr),
    .lsu_bubble     (lsu_bubble),
    .id_exception   (id_exception),
    .ex_exception   (ex_exception),
    .mem_exception  (mem_exception),
    .wb_exception   (wb_exception),
    .lsu_exception  (lsu_exception),
    .opA            (opA),
    .opB            (opB),
    .dmem_req       (dmem_req),
    .dmem_we        (dmem_we),
    .dmem_unsigned  (dmem_unsigned),
    .dmem_size      (dmem_size),
    .dmem_adr       (dmem_adr),
    .dmem_d         (dmem_d)
  );

  riscv_dmem_ram #(
    .XLEN            (XLEN),
    .DMEM_WORDS      (DMEM_WORDS)
  ) riscv_dmem_ram_inst (
    .clk             (clk),
    .rstn            (rstn),
    .dmem_req        (dmem_req),
    .dmem_we         (dmem_we),
    .dmem_size       (dmem_size),
    .dmem_adr        (dmem_adr),
    .dmem_d          (dmem_d),
    .dmem_ack        (dmem_ack),
    .dmem_q          (dmem_q),
    .dmem_misaligned (dmem_misaligned)
  );

  // Aligner only needs the byte offset
  riscv_load_align #(
    .XLEN            (XLEN)
  ) riscv_load_align_inst (
    .clk             (clk),
    .rstn            (rstn),
    .dmem_req        (dmem_req),
    .dmem_we         (dmem_we),
    .dmem_unsigned   (dmem_unsigned),
    .dmem_size       (dmem_size),
    .dmem_adr        (dmem_adr[OFS_W-1:0]),
    .dmem_ack        (dmem_ack),
    .dmem_q          (dmem_q),
    .dmem_misaligned (dmem_misaligned),
    .load_valid      (load_valid),
    .load_q          (load_q),
    .misaligned      (misaligned)
  );

endmodule

/* design/riscv_mem_pkg.sv */
// Data memory path definitions
package riscv_mem_pkg;

  ////////////////////
  // Access size

  typedef enum logic [2:0] {
    BYTE       = 3'b000,
    HWORD      = 3'b001,
    WORD       = 3'b010,
    DWORD      = 3'b011,
    UNDEF_SIZE = 3'b111  // Non-memory or illegal funct3
  } mem_size_e;

  // Number of bytes touched by one access
  function automatic logic [3:0] size_bytes(mem_size_e size);
    case (size)
      BYTE:    return 4'd1;
      HWORD:   return 4'd2;
      WORD:    return 4'd4;
      DWORD:   return 4'd8;
      default: return 4'd0;  // Nothing enabled
    endcase
  endfunction

  ////////////////////
  // Exception vector bits

  // Same positions as the mcause codes
  localparam int EXC_MISALIGNED_LOAD  = 4;
  localparam int EXC_MISALIGNED_STORE = 6;

endpackage

/* flist.f */
design/riscv_isa_pkg.sv
design/riscv_mem_pkg.sv
design/riscv_lsu.sv
design/riscv_dmem_ram.sv
design/riscv_load_align.sv
design/riscv_lsu_top.sv
testbench/riscv_lsu_checker.sv
testbench/riscv_lsu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the LSU simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module riscv_lsu_tb -f flist.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

sim_out=$(./obj_dir/Vriscv_lsu_tb)
status=$?
printf '%s\n' "$sim_out"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Test passed"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* testbench/riscv_lsu_checker.sv */
// LSU scoreboard
`timescale 1ns/100ps

module riscv_lsu_checker
  import riscv_isa_pkg::*;
#(
  parameter int XLEN           = 64,
  parameter int EXCEPTION_SIZE = 16,
  parameter int DMEM_WORDS     = 64
) (
  input  logic                      clk,
  input  logic                      rstn,

  // Stimulus as the DUT sees it
  input  logic                      ex_stall,
  input  logic                      id_bubble,
  input  logic [ILEN-1:0]           id_instr,
  input  logic [EXCEPTION_SIZE-1:0] id_exception,
  input  logic [EXCEPTION_SIZE-1:0] ex_exception,
  input  logic [EXCEPTION_SIZE-1:0] mem_exception,
  input  logic [EXCEPTION_SIZE-1:0] wb_exception,
  input  logic [XLEN-1:0]           opA,
  input  logic [XLEN-1:0]           opB,
  input  int                        row,        // -1 when idle
  input  logic [63:0]               tag,

  // DUT outputs
  input  logic                      lsu_bubble,
  input  logic [EXCEPTION_SIZE-1:0] lsu_exception,
  input  logic                      load_valid,
  input  logic [XLEN-1:0]           load_q,
  input  logic                      misaligned,

  output int                        errors,
  output int                        checks,
  output int                        rows_done
);

  localparam int MEM_BYTES = DMEM_WORDS * XLEN / 8;
  localparam int MAX_ROWS  = 64;

  // Expected response of one sampled slot
  typedef struct packed {
    logic            acc;
    logic            load;
    logic            mis;
    logic [XLEN-1:0] data;
    logic [63:0]     tag;
    int              row;
  } pred_t;

  logic [7:0]                mem [MEM_BYTES];  // Byte model of the RAM
  pred_t                     pipe [3];         // Index 2 is due now
  logic                      exp_bubble;
  logic [EXCEPTION_SIZE-1:0] exp_exc;
  bit                        armed;
  int                        row_err [MAX_ROWS];

  task automatic compare(input string name, input logic [XLEN-1:0] exp,
                         input logic [XLEN-1:0] got, input int r);
    checks++;
    if (got !== exp) begin
      errors++;
      if (r >= 0 && r < MAX_ROWS) begin
        row_err[r]++;
      end
      $display("FAIL t=%0t signal=%s expected=%h actual=%h", $time, name, exp, got);
    end
  endtask

  ////////////////////
  // Prediction at the sampling edge

  always @(posedge clk) begin
    pred_t           p;
    logic [2:0]      f3;
    logic            is_ld;
    logic            is_st;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] adr;
    int              nb;
    int              ba;

    f3    = id_instr[14:12];
    is_ld = (id_instr[6:2] == OPC_LOAD) && (f3 != 3'b111) &&
            !(XLEN == 32 && (f3 == LD || f3 == LWU));  // RV64 only codes
    is_st = (id_instr[6:2] == OPC_STORE) && !f3[2] && !(XLEN == 32 && f3 == SD);
    imm   = XLEN'($signed({id_instr[31:25], id_instr[11:7]}));  // S-type
    adr   = opA + (is_st ? imm : opB);
    nb    = 1 << f3[1:0];   // Bytes per access
    ba    = int'(adr % XLEN'(MEM_BYTES));

    p.acc  = rstn && !ex_stall && !id_bubble && (is_ld || is_st) &&
             !(|{id_exception, ex_exception, mem_exception, wb_exception});
    p.load = is_ld;
    p.mis  = (adr % XLEN'(nb)) != '0;
    p.data = '0;
    p.tag  = tag;
    p.row  = row;

    // Model updated in acceptance order, which matches RAM ordering
    if (p.acc && is_st && !p.mis) begin
      for (int i = 0; i < nb; i++) begin
        mem[ba + i] = opB[8*i +: 8];
      end
    end
    if (p.acc && is_ld && !p.mis) begin
      for (int i = 0; i < nb; i++) begin
        p.data[8*i +: 8] = mem[ba + i];
      end
      for (int i = 8 * nb; i < XLEN; i++) begin
        p.data[i] = f3[2] ? 1'b0 : p.data[8*nb - 1];  // funct3 bit 2 is unsigned
      end
    end

    if (!rstn) begin
      for (int i = 0; i < MEM_BYTES; i++) begin
        mem[i] = 8'h00;
      end
      p.row = -1;
    end

    pipe[2]    = pipe[1];
    pipe[1]    = pipe[0];
    pipe[0]    = p;
    exp_bubble = !p.acc;
    exp_exc    = rstn ? id_exception : '0;
    armed      = rstn;
  end

  ////////////////////
  // Compare mid cycle

  always @(negedge clk) begin
    pred_t last;
    logic  exp_valid;
    logic  exp_mis;
    int    r;

    if (armed) begin
      last      = pipe[2];
      r         = last.row;
      exp_valid = last.acc && last.load && !last.mis;
      exp_mis   = last.acc && last.mis;  // Stores flag it too
      compare("lsu_bubble", XLEN'(exp_bubble), XLEN'(lsu_bubble), pipe[0].row);
      compare("lsu_exception", XLEN'(exp_exc), XLEN'(lsu_exception), pipe[0].row);
      compare("load_valid", XLEN'(exp_valid), XLEN'(load_valid), r);
      compare("misaligned", XLEN'(exp_mis), XLEN'(misaligned), r);
      if (exp_valid) begin
        compare("load_q", last.data, load_q, r);
      end
      if (r >= 0 && r < MAX_ROWS) begin
        $display("test %0d %s %s", r, last.tag, (row_err[r] == 0) ? "ok" : "mismatch");
        rows_done++;
      end
    end
  end

endmodule

/* testbench/riscv_lsu_tb.sv */
// Load store unit testbench
`timescale 1ns/100ps

module riscv_lsu_tb
  import riscv_isa_pkg::*;
();

  localparam int XLEN           = 64;
  localparam int EXCEPTION_SIZE = 16;
  localparam int DMEM_WORDS     = 64;
  localparam int DRAIN_CYCLES   = 20;  // Response is due after 3 edges
  localparam int SEED           = 32'hbe6a_eb4a;

  // One stimulus slot
  typedef struct packed {
    logic [ILEN-1:0]           instr;
    logic [XLEN-1:0]           a;
    logic [XLEN-1:0]           b;
    logic [EXCEPTION_SIZE-1:0] id_exc;
    logic [EXCEPTION_SIZE-1:0] ex_exc;
    logic [EXCEPTION_SIZE-1:0] mem_exc;
    logic [EXCEPTION_SIZE-1:0] wb_exc;
    logic                      bubble;
    logic                      stall;
    logic [63:0]               tag;    // Eight characters
  } row_t;

  logic                      clk;
  logic                      rstn;
  logic                      ex_stall;
  logic                      id_bubble;
  logic [ILEN-1:0]           id_instr;
  logic [EXCEPTION_SIZE-1:0] id_exception;
  logic [EXCEPTION_SIZE-1:0] ex_exception;
  logic [EXCEPTION_SIZE-1:0] mem_exception;
  logic [EXCEPTION_SIZE-1:0] wb_exception;
  logic [XLEN-1:0]           opA;
  logic [XLEN-1:0]           opB;
  logic                      lsu_bubble;
  logic [EXCEPTION_SIZE-1:0] lsu_exception;
  logic                      load_valid;
  logic [XLEN-1:0]           load_q;
  logic                      misaligned;

  int                        cur_row;
  logic [63:0]               cur_tag;
  int                        errors;
  int                        checks;
  int                        rows_done;
  row_t                      rows [$];

  ////////////////////
  // Encoders

  function automatic logic [ILEN-1:0] load_instr(input load_funct_e f3);
    return {12'h000, 5'd10, f3, 5'd11, OPC_LOAD, 2'b11};
  endfunction

  function automatic logic [ILEN-1:0] store_instr(input logic [2:0] f3, input logic [11:0] imm);
    return {imm[11:5], 5'd12, 5'd10, f3, imm[4:0], OPC_STORE, 2'b11};
  endfunction

  function automatic logic [XLEN-1:0] rand_dword();
    return {$urandom(), $urandom()};
  endfunction

  function automatic row_t make_row(input logic [ILEN-1:0] instr, input logic [XLEN-1:0] a,
                                    input logic [XLEN-1:0] b, input logic [63:0] tag);
    row_t x;
    x       = '0;
    x.instr = instr;
    x.a     = a;
    x.b     = b;
    x.tag   = tag;
    return x;
  endfunction

  task automatic fill_table();
    row_t x;
    // Round trip starting with a load straight after the store
    rows.push_back(make_row(store_instr(SD, 12'h000), 64'h40, rand_dword(), "rt_sd   "));
    rows.push_back(make_row(load_instr(LD), 64'h40, 64'h0, "rt_ld   "));
    rows.push_back(make_row(load_instr(LW), 64'h40, 64'h4, "rt_lw_hi"));
    rows.push_back(make_row(store_instr(SW, 12'h004), 64'h80, rand_dword() | 64'h8000_0000,
                            "rt_sw   "));
    rows.push_back(make_row(load_instr(LW), 64'h80, 64'h4, "ext_lw  "));
    rows.push_back(make_row(load_instr(LWU), 64'h80, 64'h4, "ext_lwu "));
    rows.push_back(make_row(store_instr(SH, 12'h006), 64'h90, rand_dword() | 64'h8000,
                            "rt_sh   "));
    rows.push_back(make_row(load_instr(LH), 64'h96, 64'h0, "ext_lh  "));
    rows.push_back(make_row(load_instr(LHU), 64'h90, 64'h6, "ext_lhu "));
    // Negative S offset lands on 0xa3
    rows.push_back(make_row(store_instr(SB, 12'hff3), 64'hb0, rand_dword() | 64'h80,
                            "neg_sb  "));
    rows.push_back(make_row(load_instr(LB), 64'ha0, 64'h3, "ext_lb  "));
    rows.push_back(make_row(load_instr(LBU), 64'ha4, '1, "ext_lbu "));  // opB is -1
    // Misaligned accesses
    rows.push_back(make_row(load_instr(LH), 64'h41, 64'h0, "mis_lh  "));
    rows.push_back(make_row(load_instr(LW), 64'h42, 64'h0, "mis_lw  "));
    rows.push_back(make_row(load_instr(LD), 64'h44, 64'h0, "mis_ld  "));
    rows.push_back(make_row(store_instr(SW, 12'h002), 64'hc0, rand_dword(), "mis_sw  "));
    rows.push_back(make_row(load_instr(LD), 64'hc0, 64'h0, "mis_chk "));
    // Suppressed slots with one reason each
    x = make_row(store_instr(SD, 12'h000), 64'hd0, rand_dword(), "sup_bub ");
    x.bubble = 1'b1;
    rows.push_back(x);
    x = make_row(store_instr(SD, 12'h000), 64'hd8, rand_dword(), "sup_stl ");
    x.stall = 1'b1;
    rows.push_back(x);
    x = make_row(store_instr(SD, 12'h000), 64'he0, rand_dword(), "sup_idx ");
    x.id_exc = 16'h0004;
    rows.push_back(x);
    x = make_row(store_instr(SD, 12'h000), 64'he8, rand_dword(), "sup_exx ");
    x.ex_exc = 16'h0001;
    rows.push_back(x);
    x = make_row(store_instr(SD, 12'h000), 64'hf0, rand_dword(), "sup_mem ");
    x.mem_exc = 16'h8000;
    rows.push_back(x);
    x = make_row(store_instr(SD, 12'h000), 64'hf8, rand_dword(), "sup_wb  ");
    x.wb_exc = 16'h0040;
    rows.push_back(x);
    rows.push_back(make_row({12'h000, 5'd10, 3'b011, 5'd11, OPC_OP_IMM, 2'b11}, 64'hd0,
                            rand_dword(), "sup_alu "));
    rows.push_back(make_row(store_instr(3'b100, 12'h000), 64'hd0, rand_dword(), "sup_f3  "));
    for (int k = 0; k < 6; k++) begin
      rows.push_back(make_row(load_instr(LD), 64'hd0 + 64'(8 * k), 64'h0, "sup_chk "));
    end
  endtask

  task automatic drive_row(input row_t x, input int idx);
    id_instr      = x.instr;
    opA           = x.a;
    opB           = x.b;
    id_exception  = x.id_exc;
    ex_exception  = x.ex_exc;
    mem_exception = x.mem_exc;
    wb_exception  = x.wb_exc;
    id_bubble     = x.bubble;
    ex_stall      = x.stall;
    cur_row       = idx;
    cur_tag       = x.tag;
  endtask

  ////////////////////
  // Clock and sequence

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    row_t idle;
    int   waited;
    void'($urandom(SEED));
    fill_table();
    idle        = make_row(32'h0000_0013, '0, '0, "idle    ");  // addi x0, x0, 0
    idle.bubble = 1'b1;
    drive_row(idle, -1);
    rstn = 1'b0;
    repeat (2) @(posedge clk);  // Two rising edges in reset
    @(negedge clk);
    rstn = 1'b1;

    foreach (rows[i]) begin
      @(negedge clk);
      drive_row(rows[i], i);
    end
    @(negedge clk);
    drive_row(idle, -1);

    // Drain until every slot has been scored
    waited = 0;
    while (rows_done < rows.size() && waited < DRAIN_CYCLES) begin
      @(posedge clk);
      waited++;
    end

    if (rows_done < rows.size()) begin
      $display("Timeout: only %0d of %0d tests were scored", rows_done, rows.size());
      $display("Test failed");
    end else begin
      $display("Summary: %0d tests, %0d checks, %0d errors", rows_done, checks, errors);
      if (errors == 0) begin
        $display("Test passed");
      end else begin
        $display("Test failed");
      end
    end
    $finish;
  end

  ////////////////////
  // DUT and scoreboard

  riscv_lsu_top #(
    .XLEN           (XLEN),
    .EXCEPTION_SIZE (EXCEPTION_SIZE),
    .DMEM_WORDS     (DMEM_WORDS)
  ) riscv_lsu_top_inst (
    .clk            (clk),
    .rstn           (rstn),
    .ex_stall       (ex_stall),
    .id_bubble      (id_bubble),
    .id_instr       (id_instr),
    .id_exception   (id_exception),
    .ex_exception   (ex_exception),
    .mem_exception  (mem_exception),
    .wb_exception   (wb_exception),
    .opA            (opA),
    .opB            (opB),
    .lsu_bubble     (lsu_bubble),
    .lsu_exception  (lsu_exception),
    .load_valid     (load_valid),
    .load_q         (load_q),
    .misaligned     (misaligned)
  );

  riscv_lsu_checker #(
    .XLEN           (XLEN),
    .EXCEPTION_SIZE (EXCEPTION_SIZE),
    .DMEM_WORDS     (DMEM_WORDS)
  ) riscv_lsu_checker_inst (
    .clk            (clk),
    .rstn           (rstn),
    .ex_stall       (ex_stall),
    .id_bubble      (id_bubble),
    .id_instr       (id_instr),
    .id_exception   (id_exception),
    .ex_exception   (ex_exception),
    .mem_exception  (mem_exception),
    .wb_exception   (wb_exception),
    .opA            (opA),
    .opB            (opB),
    .row            (cur_row),
    .tag            (cur_tag),
    .lsu_bubble     (lsu_bubble),
    .lsu_exception  (lsu_exception),
    .load_valid     (load_valid),
    .load_q         (load_q),
    .misaligned     (misaligned),
    .errors         (errors),
    .checks         (checks),
    .rows_done      (rows_done)
  );

endmodule
